/* design/gat_defs.svh */
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// Data widths
`define DATA_WIDTH         8
`define WH_DATA_WIDTH      12

// Graph and feature sizes
`define TOTAL_NODES        20
`define NUM_FEATURE_IN     16
`define NUM_FEATURE_OUT    7
`define MAX_NODES          9

// H memory depth, one entry per nonzero
`define H_NUM_SPARSE_DATA  140

// Field widths
`define COL_IDX_WIDTH      4
`define ROW_LEN_WIDTH      5
`define NUM_NODE_WIDTH     4

// Address widths
`define H_ADDR_W           8
`define NODE_ADDR_W        5

`endif

/* design/gat_pkg.sv */
`include "gat_defs.svh"

package gat_pkg;

  // One H nonzero as stored in memory
  typedef struct packed {
    logic [`DATA_WIDTH-1:0]     value;
    logic [`COL_IDX_WIDTH-1:0]  col;
  } h_data_t;

  // Per-node row descriptor
  typedef struct packed {
    logic [`ROW_LEN_WIDTH-1:0]  row_len;
    logic [`NUM_NODE_WIDTH-1:0] num_node;
    logic                       flag;
  } node_info_t;

  // Nonzero in flight from fetch to MAC
  typedef struct packed {
    logic [`DATA_WIDTH-1:0]     value;
    logic [`COL_IDX_WIDTH-1:0]  col;
    logic                       last;
    logic [`NUM_NODE_WIDTH-1:0] num_node;
    logic                       flag;
  } h_item_t;

  // W indexed as [out column][in row]
  typedef logic [`NUM_FEATURE_OUT-1:0][`NUM_FEATURE_IN-1:0][`DATA_WIDTH-1:0] weight_t;

  typedef struct packed {
    logic [`NUM_FEATURE_OUT-1:0][`WH_DATA_WIDTH-1:0] data;
    logic [`NUM_NODE_WIDTH-1:0]                      num_node;
    logic                                            flag;
  } wh_row_t;

endpackage

/* design/bram.sv */
`timescale 1ns/1ps

module bram #(
  parameter int  DEPTH  = 16,
  parameter type word_t = logic [7:0]
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wea,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  word_t                    din,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output word_t                    dout
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= din;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

endmodule

/* design/spmm_fetch.sv */
`timescale 1ns/1ps
`include "gat_defs.svh"

module spmm_fetch (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    spmm_vld,
  output logic                    spmm_rdy,
  output logic [`NODE_ADDR_W-1:0] node_addr,
  input  gat_pkg::node_info_t     node_info,
  output logic [`H_ADDR_W-1:0]    h_addr,
  input  gat_pkg::h_data_t        h_data,
  input  logic                    row_done,
  output gat_pkg::h_item_t        item,
  output logic                    item_vld
);
  import gat_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_INFO,
    S_DATA,
    S_STREAM,
    S_DRAIN
  } state_t;

  localparam logic [`NODE_ADDR_W-1:0] LAST_NODE = `TOTAL_NODES - 1;

  state_t                    state;
  node_info_t                info_q;
  logic [`ROW_LEN_WIDTH-1:0] cnt;
  logic [`H_ADDR_W-1:0]      h_ptr;
  logic [`NODE_ADDR_W-1:0]   rows_done;
  logic                      last_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      info_q    <= '0;
      cnt       <= '0;
      h_ptr     <= '0;
      node_addr <= '0;
      rows_done <= '0;
      item_vld  <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      item_vld <= (state == S_STREAM);
      last_q   <= (state == S_STREAM) && (cnt == 1);
      if (row_done) begin
        rows_done <= rows_done + 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (spmm_vld) begin
            state     <= S_INFO;
            node_addr <= '0;
            h_ptr     <= '0;
            rows_done <= '0;
          end
        end
        S_INFO: state <= S_DATA;
        S_DATA: begin
          info_q <= node_info;
          cnt    <= node_info.row_len;
          state  <= S_STREAM;
        end
        S_STREAM: begin
          h_ptr <= h_ptr + 1'b1;
          cnt   <= cnt - 1'b1;
          if (cnt == 1) begin
            if (node_addr == LAST_NODE) begin
              state <= S_DRAIN;
            end else begin
              node_addr <= node_addr + 1'b1;
              state     <= S_INFO;
            end
          end
        end
        default: ;
      endcase
      // Run ends on the last row written by the MAC
      if (state != S_IDLE && row_done && rows_done == LAST_NODE) begin
        state <= S_IDLE;
      end
    end
  end

  assign spmm_rdy = (state == S_IDLE);
  assign h_addr   = h_ptr;

  // info_q only changes two cycles after a row's last address,
  // so it still tags that row's final item
  always_comb begin
    item.value    = h_data.value;
    item.col      = h_data.col;
    item.last     = last_q;
    item.num_node = info_q.num_node;
    item.flag     = info_q.flag;
  end

endmodule

/* design/spmm_mac.sv */
`timescale 1ns/1ps
`include "gat_defs.svh"

module spmm_mac (
  input  logic                    clk,
  input  logic                    arst_n,
  input  gat_pkg::h_item_t        item,
  input  logic                    item_vld,
  input  gat_pkg::weight_t        wgt,
  output gat_pkg::wh_row_t        wh_bram_din,
  output logic                    wh_bram_ena,
  output logic [`NODE_ADDR_W-1:0] wh_bram_addra,
  output logic                    row_done
);

  localparam logic [`NODE_ADDR_W-1:0] LAST_ADDR = `TOTAL_NODES - 1;

  logic [`NUM_FEATURE_OUT-1:0][`WH_DATA_WIDTH-1:0] prod;
  logic [`NUM_FEATURE_OUT-1:0][`WH_DATA_WIDTH-1:0] acc;
  logic [`NUM_FEATURE_OUT-1:0][`WH_DATA_WIDTH-1:0] sum;
  logic                                            prod_vld;
  logic                                            prod_last;
  logic [`NUM_NODE_WIDTH-1:0]                      prod_num_node;
  logic                                            prod_flag;

  // Stage 1 multiplies against the W row picked by the column index
  always_ff @(posedge clk) begin
    if (item_vld) begin
      for (int j = 0; j < `NUM_FEATURE_OUT; j++) begin
        // Evaluated at 12 bits, so the product is already mod 4096
        prod[j] <= item.value * wgt[j][item.col];
      end
      prod_last     <= item.last;
      prod_num_node <= item.num_node;
      prod_flag     <= item.flag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_vld <= 1'b0;
    end else begin
      prod_vld <= item_vld;
    end
  end

  always_comb begin
    for (int j = 0; j < `NUM_FEATURE_OUT; j++) begin
      sum[j] = acc[j] + prod[j];
    end
  end

  // Stage 2 accumulates and hands finished rows to the write port
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc           <= '0;
      wh_bram_din   <= '0;
      wh_bram_ena   <= 1'b0;
      wh_bram_addra <= '0;
    end else begin
      wh_bram_ena <= prod_vld && prod_last;
      if (prod_vld) begin
        if (prod_last) begin
          acc                  <= '0;
          wh_bram_din.data     <= sum;
          wh_bram_din.num_node <= prod_num_node;
          wh_bram_din.flag     <= prod_flag;
        end else begin
          acc <= sum;
        end
      end
      // Address steps after each write and wraps at the last node
      if (wh_bram_ena) begin
        wh_bram_addra <= (wh_bram_addra == LAST_ADDR) ? '0 : wh_bram_addra + 1'b1;
      end
    end
  end

  assign row_done = wh_bram_ena;

endmodule

/* design/wh_top.sv */
`timescale 1ns/1ps
`include "gat_defs.svh"

module wh_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  gat_pkg::h_data_t        h_data_bram_din,
  input  logic [`H_ADDR_W-1:0]    h_data_bram_addra,
  input  logic                    h_data_bram_wea,
  input  gat_pkg::node_info_t     node_info_bram_din,
  input  logic [`NODE_ADDR_W-1:0] node_info_bram_addra,
  input  logic                    node_info_bram_wea,
  input  gat_pkg::weight_t        wgt,
  input  logic                    spmm_vld,
  output logic                    spmm_rdy,
  output gat_pkg::wh_row_t        wh_bram_din,
  output logic                    wh_bram_ena,
  output logic [`NODE_ADDR_W-1:0] wh_bram_addra
);
  import gat_pkg::*;

  logic [`H_ADDR_W-1:0]    h_addr;
  h_data_t                 h_data;
  logic [`NODE_ADDR_W-1:0] node_addr;
  node_info_t              node_info;
  h_item_t                 item;
  logic                    item_vld;
  logic                    row_done;

  bram #(
    .DEPTH  (`H_NUM_SPARSE_DATA),
    .word_t (h_data_t)
  ) u_h_data_bram (
    .clk    (clk),
    .arst_n (arst_n),
    .wea    (h_data_bram_wea),
    .addra  (h_data_bram_addra),
    .din    (h_data_bram_din),
    .addrb  (h_addr),
    .dout   (h_data)
  );

  bram #(
    .DEPTH  (`TOTAL_NODES),
    .word_t (node_info_t)
  ) u_node_info_bram (
    .clk    (clk),
    .arst_n (arst_n),
    .wea    (node_info_bram_wea),
    .addra  (node_info_bram_addra),
    .din    (node_info_bram_din),
    .addrb  (node_addr),
    .dout   (node_info)
  );

  spmm_fetch u_spmm_fetch (
    .clk       (clk),
    .arst_n    (arst_n),
    .spmm_vld  (spmm_vld),
    .spmm_rdy  (spmm_rdy),
    .node_addr (node_addr),
    .node_info (node_info),
    .h_addr    (h_addr),
    .h_data    (h_data),
    .row_done  (row_done),
    .item      (item),
    .item_vld  (item_vld)
  );

  spmm_mac u_spmm_mac (
    .clk           (clk),
    .arst_n        (arst_n),
    .item          (item),
    .item_vld      (item_vld),
    .wgt           (wgt),
    .wh_bram_din   (wh_bram_din),
    .wh_bram_ena   (wh_bram_ena),
    .wh_bram_addra (wh_bram_addra),
    .row_done      (row_done)
  );

endmodule

/* test/wh_assertions.sv */
`timescale 1ns/1ps
`include "gat_defs.svh"

module wh_assertions (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    spmm_rdy,
  input logic                    wh_bram_ena,
  input logic [`NODE_ADDR_W-1:0] wh_bram_addra,
  input gat_pkg::wh_row_t        wh_bram_din
);

  localparam logic [`NODE_ADDR_W-1:0] LAST_ADDR = `TOTAL_NODES - 1;

  int fail_cnt = 0;

  // Writes only happen inside a run
  assert property (@(posedge clk) disable iff (!arst_n) wh_bram_ena |-> !spmm_rdy)
    else begin
      fail_cnt++;
      $error("wh_bram_ena high while spmm_rdy is high");
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    wh_bram_ena |=> (wh_bram_addra == (($past(wh_bram_addra) == LAST_ADDR) ?
                                       '0 : $past(wh_bram_addra) + 1'b1)))
    else begin
      fail_cnt++;
      $error("wh_bram_addra did not advance by one after a write");
    end

  assert property (@(posedge clk) disable iff (!arst_n) !wh_bram_ena |=> $stable(wh_bram_addra))
    else begin
      fail_cnt++;
      $error("wh_bram_addra moved without a write");
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown({spmm_rdy, wh_bram_ena, wh_bram_addra, wh_bram_din}))
    else begin
      fail_cnt++;
      $error("unknown value on a wh_top output");
    end

endmodule

bind wh_top wh_assertions u_wh_assertions (
  .clk           (clk),
  .arst_n        (arst_n),
  .spmm_rdy      (spmm_rdy),
  .wh_bram_ena   (wh_bram_ena),
  .wh_bram_addra (wh_bram_addra),
  .wh_bram_din   (wh_bram_din)
);

/* test/wh_tb.sv */
`timescale 1ns/1ps
`include "gat_defs.svh"

module wh_tb;
  import gat_pkg::*;

  localparam int N     = `TOTAL_NODES;
  localparam int F_IN  = `NUM_FEATURE_IN;
  localparam int F_OUT = `NUM_FEATURE_OUT;

  logic                    clk;
  logic                    arst_n;
  h_data_t                 h_data_bram_din;
  logic [`H_ADDR_W-1:0]    h_data_bram_addra;
  logic                    h_data_bram_wea;
  node_info_t              node_info_bram_din;
  logic [`NODE_ADDR_W-1:0] node_info_bram_addra;
  logic                    node_info_bram_wea;
  weight_t                 wgt;
  logic                    spmm_vld;
  logic                    spmm_rdy;
  wh_row_t                 wh_bram_din;
  logic                    wh_bram_ena;
  logic [`NODE_ADDR_W-1:0] wh_bram_addra;

  // Row length, subgraph size and subgraph start per node
  int tab_len [N]      = '{1, 16, 5, 3, 8, 2, 7, 4, 12, 6, 9, 1, 10, 3, 16, 5, 2, 11, 4, 7};
  int tab_num_node [N] = '{3, 3, 3, 4, 4, 4, 4, 2, 2, 9, 9, 9, 9, 9, 9, 9, 9, 9, 2, 2};
  int tab_flag [N]     = '{1, 0, 0, 1, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0};

  logic [`DATA_WIDTH-1:0]    h_val [`H_NUM_SPARSE_DATA];
  logic [`COL_IDX_WIDTH-1:0] h_col [`H_NUM_SPARSE_DATA];
  logic [`WH_DATA_WIDTH-1:0] exp_wh [N][F_OUT];
  logic [31:0]               rng_state;
  int                        cycle_cnt = 0;
  int                        err_cnt = 0;

  wh_top dut0 (
    .clk                  (clk),
    .arst_n               (arst_n),
    .h_data_bram_din      (h_data_bram_din),
    .h_data_bram_addra    (h_data_bram_addra),
    .h_data_bram_wea      (h_data_bram_wea),
    .node_info_bram_din   (node_info_bram_din),
    .node_info_bram_addra (node_info_bram_addra),
    .node_info_bram_wea   (node_info_bram_wea),
    .wgt                  (wgt),
    .spmm_vld             (spmm_vld),
    .spmm_rdy             (spmm_rdy),
    .wh_bram_din          (wh_bram_din),
    .wh_bram_ena          (wh_bram_ena),
    .wh_bram_addra        (wh_bram_addra)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic int sum_row_len();
    int s;
    s = 0;
    for (int n = 0; n < N; n++) begin
      s += tab_len[n];
    end
    return s;
  endfunction

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 4 * sum_row_len() + 200) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_cnt);
      $display("Checks failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  always @(negedge clk) begin
    if (dut0.u_wh_assertions.fail_cnt != 0) begin
      $display("An assertion on the WH write port or handshake failed at %0t ns", $time);
      $display("Checks failed");
      $fatal(1, "simulation stopped on assertion failure");
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL @ %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic build_h();
    int ptr;
    int need;
    logic [31:0] r;
    ptr = 0;
    for (int n = 0; n < N; n++) begin
      need = tab_len[n];
      for (int c = 0; c < F_IN; c++) begin
        r = next_rand();
        // Selection sampling keeps columns distinct and ascending
        if (need > 0 && (r % (F_IN - c)) < need) begin
          h_col[ptr] = 4'(c);
          r = next_rand();
          h_val[ptr] = 8'(r % 255 + 1);
          ptr++;
          need--;
        end
      end
    end
  endtask

  task automatic fill_weights(output weight_t w);
    logic [31:0] r;
    for (int j = 0; j < F_OUT; j++) begin
      for (int i = 0; i < F_IN; i++) begin
        r = next_rand();
        w[j][i] = r[7:0];
      end
    end
  endtask

  // Dot products of each sparse row with the W columns, mod 4096
  task automatic compute_expected(input weight_t w);
    int ptr;
    int acc;
    ptr = 0;
    for (int n = 0; n < N; n++) begin
      for (int j = 0; j < F_OUT; j++) begin
        acc = 0;
        for (int k = 0; k < tab_len[n]; k++) begin
          acc += int'(h_val[ptr + k]) * int'(w[j][h_col[ptr + k]]);
        end
        exp_wh[n][j] = 12'(acc % 4096);
      end
      ptr += tab_len[n];
    end
  endtask

  task automatic load_memories();
    h_data_t    hd;
    node_info_t ni;
    for (int k = 0; k < sum_row_len(); k++) begin
      @(posedge clk);
      hd.value = h_val[k];
      hd.col   = h_col[k];
      h_data_bram_wea   <= 1'b1;
      h_data_bram_addra <= 8'(k);
      h_data_bram_din   <= hd;
    end
    @(posedge clk);
    h_data_bram_wea <= 1'b0;
    for (int n = 0; n < N; n++) begin
      ni.row_len  = 5'(tab_len[n]);
      ni.num_node = 4'(tab_num_node[n]);
      ni.flag     = tab_flag[n][0];
      node_info_bram_wea   <= 1'b1;
      node_info_bram_addra <= 5'(n);
      node_info_bram_din   <= ni;
      @(posedge clk);
    end
    node_info_bram_wea <= 1'b0;
  endtask

  task automatic run_and_check(input int run_idx);
    int writes;
    int gap;
    @(posedge clk);
    spmm_vld <= 1'b1;
    @(posedge clk);
    spmm_vld <= 1'b0;
    @(negedge clk);
    check_value($sformatf("run %0d spmm_rdy after start", run_idx), spmm_rdy, 0);
    writes = 0;
    gap = 0;
    do begin
      @(negedge clk);
      gap++;
      if (wh_bram_ena) begin
        if (writes < N) begin
          check_value($sformatf("run %0d row %0d address", run_idx, writes),
                      wh_bram_addra, writes);
          check_value($sformatf("run %0d row %0d num_node", run_idx, writes),
                      wh_bram_din.num_node, tab_num_node[writes]);
          check_value($sformatf("run %0d row %0d flag", run_idx, writes),
                      wh_bram_din.flag, tab_flag[writes]);
          for (int j = 0; j < F_OUT; j++) begin
            check_value($sformatf("run %0d row %0d element %0d", run_idx, writes, j),
                        wh_bram_din.data[j], exp_wh[writes][j]);
          end
        end
        writes++;
        gap = 0;
      end
    end while (!spmm_rdy);
    check_value($sformatf("run %0d write count", run_idx), writes, N);
    check_value($sformatf("run %0d cycles from last write to spmm_rdy", run_idx), gap, 1);
    // No stray writes once idle
    repeat (10) begin
      @(negedge clk);
      check_value($sformatf("run %0d spmm_rdy when idle", run_idx), spmm_rdy, 1);
      check_value($sformatf("run %0d wh_bram_ena when idle", run_idx), wh_bram_ena, 0);
    end
  endtask

  initial begin
    weight_t w;
    arst_n               = 1'b0;
    spmm_vld             = 1'b0;
    h_data_bram_din      = '0;
    h_data_bram_addra    = '0;
    h_data_bram_wea      = 1'b0;
    node_info_bram_din   = '0;
    node_info_bram_addra = '0;
    node_info_bram_wea   = 1'b0;
    wgt                  = '0;
    rng_state            = 32'd46;
    build_h();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("spmm_rdy after reset", spmm_rdy, 1);
    check_value("wh_bram_ena after reset", wh_bram_ena, 0);
    load_memories();
    for (int run = 1; run <= 2; run++) begin
      fill_weights(w);
      @(posedge clk);
      wgt <= w;
      compute_expected(w);
      run_and_check(run);
    end
    if (err_cnt == 0 && dut0.u_wh_assertions.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/gat_pkg.sv
design/bram.sv
design/spmm_fetch.sv
design/spmm_mac.sv
design/wh_top.sv
test/wh_assertions.sv
test/wh_tb.sv

/* Bender.yml */
package:
  name: gat_wh

sources:
  - include_dirs:
      - design
    files:
      - design/gat_pkg.sv
      - design/bram.sv
      - design/spmm_fetch.sv
      - design/spmm_mac.sv
      - design/wh_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/wh_assertions.sv
      - test/wh_tb.sv
